// ==== logic/ddr2_odt_pkg.sv ====
/*
 * Shared types and limits for the DDR2 ODT generator.
 * Holds the controller configuration layout, the derived timing bundle
 * passed from the latency block to the lanes, the per-lane window state
 * and the h/l ODT pair. Referenced by scoped names from every module.
 */

`default_nettype none

package ddr2_odt_pkg;

    // latency value, used for tCL, tCWL and the pipe tap index
    typedef logic [3:0] tcl_t;

    typedef logic [2:0] add_lat_t;

    // burst length in DRAM beats, 4 or 8
    typedef logic [4:0] burst_len_t;

    // window length in controller cycles
    typedef logic [3:0] beats_t;

    typedef struct packed {
        tcl_t       tcl;
        add_lat_t   add_lat;
        burst_len_t burst_length;
        logic       output_regd;
    } odt_cfg_t;

    typedef struct packed {
        tcl_t   tcwl;
        logic   tcwl_even;
        tcl_t   wr_tap;
        tcl_t   rd_tap;
        logic   wr_bypass;
        logic   rd_bypass;
        beats_t beats;
    } odt_timing_t;

    typedef struct packed {
        logic start;
        logic mid;
        logic last;
    } lane_state_t;

    typedef struct packed {
        logic h;
        logic l;
    } odt_pair_t;

    // every tap value of tcl_t must index the command pipe
    localparam int PIPE_DEPTH = 2 ** $bits(tcl_t);

    // below these tCWL values the command goes straight through
    localparam tcl_t WR_BYPASS_LIMIT = 4'd4;
    localparam tcl_t RD_BYPASS_LIMIT = 4'd3;

endpackage

`default_nettype wire

// ==== logic/odt_latency_cfg.sv ====
/*
 * Write latency calculation for the ODT generator.
 * Turns the quasi-static controller configuration into tCWL, its parity,
 * the command pipe taps, the bypass flags and the window length in
 * controller cycles. tCWL settles two cycles after a configuration change
 * and the derived fields one cycle later.
 */

`default_nettype none

module odt_latency_cfg #(
    parameter int DWIDTH_RATIO = 4
) (
    input  logic                      ctl_clk,
    input  logic                      ctl_reset_n,
    input  ddr2_odt_pkg::odt_cfg_t    cfg,
    output ddr2_odt_pkg::odt_timing_t timing
);

    // DRAM clocks per controller cycle
    localparam ddr2_odt_pkg::tcl_t HALF_RATIO = ddr2_odt_pkg::tcl_t'(DWIDTH_RATIO / 2);

    ddr2_odt_pkg::tcl_t        regd_q;
    ddr2_odt_pkg::tcl_t        tcwl_next;
    ddr2_odt_pkg::odt_timing_t timing_q;

    // output register adds one DRAM clock per controller half cycle
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            regd_q <= '0;
        end
        else
        begin
            regd_q <= cfg.output_regd ? HALF_RATIO : '0;
        end
    end

    always_comb
    begin
        tcwl_next = cfg.tcl + ddr2_odt_pkg::tcl_t'(cfg.add_lat) + regd_q
                    - ddr2_odt_pkg::tcl_t'(1);
    end

    // tcwl is stage two, everything derived from it is stage three
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            timing_q <= '0;
        end
        else
        begin
            timing_q.tcwl      <= tcwl_next;
            timing_q.tcwl_even <= ~timing_q.tcwl[0];
            // taps wrap for short tcwl, the bypass flag hides that case
            timing_q.wr_tap    <= (timing_q.tcwl - ddr2_odt_pkg::WR_BYPASS_LIMIT)
                                  / HALF_RATIO;
            timing_q.rd_tap    <= (timing_q.tcwl - ddr2_odt_pkg::RD_BYPASS_LIMIT)
                                  / HALF_RATIO;
            timing_q.wr_bypass <= timing_q.tcwl < ddr2_odt_pkg::WR_BYPASS_LIMIT;
            timing_q.rd_bypass <= timing_q.tcwl < ddr2_odt_pkg::RD_BYPASS_LIMIT;
            timing_q.beats     <= ddr2_odt_pkg::beats_t'(cfg.burst_length / DWIDTH_RATIO);
        end
    end

    assign timing = timing_q;

endmodule

`default_nettype wire

// ==== logic/odt_cmd_lane.sv ====
/*
 * One command lane of the ODT generator, used once for writes and once
 * for reads. Delays the command pulse by the selected tap so the window
 * lines up with the DQ/DQS burst, then tracks the burst with a counter.
 * start is combinational, mid and last are registered flags.
 */

`default_nettype none

module odt_cmd_lane (
    input  logic                      ctl_clk,
    input  logic                      ctl_reset_n,
    input  logic                      cmd,
    input  ddr2_odt_pkg::tcl_t        tap,
    input  logic                      bypass,
    input  ddr2_odt_pkg::beats_t      beats,
    output ddr2_odt_pkg::lane_state_t state
);

    logic [ddr2_odt_pkg::PIPE_DEPTH-1:0] pipe_q;
    logic                                start;
    ddr2_odt_pkg::beats_t                cnt_q;
    ddr2_odt_pkg::beats_t                cnt_next;
    logic                                mid_q;
    logic                                last_q;

    // bit n holds the command from n+1 cycles ago
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            pipe_q <= '0;
        end
        else
        begin
            pipe_q <= {pipe_q[ddr2_odt_pkg::PIPE_DEPTH-2:0], cmd};
        end
    end

    always_comb
    begin
        if (bypass)
        begin
            start = cmd;
        end
        else
        begin
            start = pipe_q[tap];
        end
    end

    assign cnt_next = cnt_q + ddr2_odt_pkg::beats_t'(1);

    // cnt_q is the offset of the current cycle from the start cycle
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            cnt_q  <= '0;
            mid_q  <= 1'b0;
            last_q <= 1'b0;
        end
        else if (start)
        begin
            // a fresh start restarts the window
            cnt_q  <= ddr2_odt_pkg::beats_t'(1);
            mid_q  <= beats > ddr2_odt_pkg::beats_t'(1);
            last_q <= beats == ddr2_odt_pkg::beats_t'(1);
        end
        else if (cnt_q != '0)
        begin
            if (cnt_q >= beats)
            begin
                cnt_q  <= '0;
                mid_q  <= 1'b0;
                last_q <= 1'b0;
            end
            else
            begin
                cnt_q  <= cnt_next;
                mid_q  <= cnt_next < beats;
                last_q <= cnt_next == beats;
            end
        end
    end

    assign state = '{start: start, mid: mid_q, last: last_q};

endmodule

`default_nettype wire

// ==== logic/odt_phase_gen.sv ====
/*
 * ODT phase shaping for the two halves of a controller cycle.
 * Full rate drives h and l together over the whole window. Half rate
 * trims the first and last cycle to the DRAM clock the burst really
 * starts or ends on, which depends on the tCWL parity and the command
 * type. Purely combinational, adds no latency.
 */

`default_nettype none

module odt_phase_gen #(
    parameter int DWIDTH_RATIO = 4
) (
    input  ddr2_odt_pkg::lane_state_t wr_lane,
    input  ddr2_odt_pkg::lane_state_t rd_lane,
    input  logic                      tcwl_even,
    output ddr2_odt_pkg::odt_pair_t   odt
);

    // window shape of one lane at half rate
    function automatic ddr2_odt_pkg::odt_pair_t shape_edge(
        input ddr2_odt_pkg::lane_state_t lane,
        input logic                      edge_short
    );
        ddr2_odt_pkg::odt_pair_t pair;
        pair = '0;
        if (lane.start)
        begin
            pair.h = 1'b1;
            pair.l = edge_short;
        end
        else if (lane.mid)
        begin
            pair.h = 1'b1;
            pair.l = 1'b1;
        end
        else if (lane.last)
        begin
            pair.h = ~edge_short;
            pair.l = 1'b1;
        end
        return pair;
    endfunction

    generate
        if (DWIDTH_RATIO == 2)
        begin : g_full_rate
            logic any_active;

            assign any_active = (|wr_lane) | (|rd_lane);
            assign odt        = '{h: any_active, l: any_active};
        end
        else
        begin : g_half_rate
            ddr2_odt_pkg::odt_pair_t wr_pair;
            ddr2_odt_pkg::odt_pair_t rd_pair;

            // reads land half a cycle off writes for the same parity
            always_comb
            begin
                wr_pair = shape_edge(wr_lane, tcwl_even);
                rd_pair = shape_edge(rd_lane, ~tcwl_even);
            end

            // write wins if both lanes are active
            always_comb
            begin
                if (|wr_lane)
                begin
                    odt = wr_pair;
                end
                else
                begin
                    odt = rd_pair;
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// ==== logic/ddr2_odt_top.sv ====
/*
 * Top level of the DDR2 ODT generator.
 * Takes write and read command pulses from the bank/command logic and
 * produces the h/l ODT phases aligned to the DQ/DQS burst. Set
 * DWIDTH_RATIO to 2 for full rate or 4 for half rate.
 */

`default_nettype none

module ddr2_odt_top #(
    parameter int DWIDTH_RATIO = 4
) (
    input  logic                    ctl_clk,
    input  logic                    ctl_reset_n,
    input  ddr2_odt_pkg::odt_cfg_t  cfg,
    input  logic                    do_write,
    input  logic                    do_read,
    output ddr2_odt_pkg::odt_pair_t odt
);

    ddr2_odt_pkg::odt_timing_t timing;
    ddr2_odt_pkg::lane_state_t wr_lane;
    ddr2_odt_pkg::lane_state_t rd_lane;

    odt_latency_cfg #(
        .DWIDTH_RATIO (DWIDTH_RATIO)
    ) u_latency_cfg (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cfg         (cfg),
        .timing      (timing)
    );

    odt_cmd_lane u_wr_lane (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cmd         (do_write),
        .tap         (timing.wr_tap),
        .bypass      (timing.wr_bypass),
        .beats       (timing.beats),
        .state       (wr_lane)
    );

    odt_cmd_lane u_rd_lane (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cmd         (do_read),
        .tap         (timing.rd_tap),
        .bypass      (timing.rd_bypass),
        .beats       (timing.beats),
        .state       (rd_lane)
    );

    odt_phase_gen #(
        .DWIDTH_RATIO (DWIDTH_RATIO)
    ) u_phase_gen (
        .wr_lane   (wr_lane),
        .rd_lane   (rd_lane),
        .tcwl_even (timing.tcwl_even),
        .odt       (odt)
    );

endmodule

`default_nettype wire

// ==== dv/ddr2_odt_properties.sv ====
/*
 * Concurrent assertions for the DDR2 ODT generator top level.
 * Bound to every ddr2_odt_top instance. Covers the reset value of odt,
 * the h/l equality at full rate and the start/last exclusion per lane.
 */

`default_nettype none

module ddr2_odt_properties #(
    parameter int DWIDTH_RATIO = 4
) (
    input logic                      ctl_clk,
    input logic                      ctl_reset_n,
    input ddr2_odt_pkg::odt_pair_t   odt,
    input ddr2_odt_pkg::lane_state_t wr_lane,
    input ddr2_odt_pkg::lane_state_t rd_lane
);

    // all registers clear under reset, so no window can be open
    a_reset_quiet: assert property (@(posedge ctl_clk) !ctl_reset_n |-> odt == '0)
        else $error("odt active while reset is asserted");

    generate
        if (DWIDTH_RATIO == 2)
        begin : g_full_rate
            a_full_rate_equal: assert property (
                @(posedge ctl_clk) disable iff (!ctl_reset_n) odt.h == odt.l)
                else $error("h and l differ at full rate");
        end
    endgenerate

    // a window never ends in the cycle that opens it
    a_wr_start_last: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n) !(wr_lane.start && wr_lane.last))
        else $error("write lane start and last in one cycle");

    a_rd_start_last: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n) !(rd_lane.start && rd_lane.last))
        else $error("read lane start and last in one cycle");

endmodule

bind ddr2_odt_top ddr2_odt_properties #(
    .DWIDTH_RATIO (DWIDTH_RATIO)
) u_properties (
    .ctl_clk     (ctl_clk),
    .ctl_reset_n (ctl_reset_n),
    .odt         (odt),
    .wr_lane     (wr_lane),
    .rd_lane     (rd_lane)
);

`default_nettype wire

// ==== dv/ddr2_odt_tb.sv ====
/*
 * Directed testbench for the DDR2 ODT generator.
 * Runs a half-rate DUT and a full-rate DUT from the same stimulus and
 * checks odt every cycle against a model built from the latency rules.
 * Stops at the first mismatch and a watchdog bounds the run time.
 */

`default_nettype none

module ddr2_odt_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 5;
    localparam int CFG_IDLE     = 4;
    // longer than the command pipe so no old command can refire
    localparam int DRAIN_CYCLES = 20;
    localparam int MAX_CMDS     = 6;
    localparam int MAX_SLOT     = 11;
    localparam int N_CFGS       = 10;
    localparam int TEST_CYCLES  = 3 * RESET_CYCLES
                                  + N_CFGS * (1 + CFG_IDLE + MAX_CMDS * MAX_SLOT + DRAIN_CYCLES);
    localparam int HIST_LEN     = 4096;
    localparam int RANDOM_SEED  = 55095;

    localparam int SWEEP_TCL  [5] = '{3, 4, 6, 4, 7};
    localparam int SWEEP_AL   [5] = '{1, 0, 3, 2, 4};
    localparam bit SWEEP_REGD [5] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};

    logic                      ctl_clk;
    logic                      ctl_reset_n;
    ddr2_odt_pkg::odt_cfg_t    cfg;
    logic                      do_write;
    logic                      do_read;
    ddr2_odt_pkg::odt_pair_t   odt_hr;
    ddr2_odt_pkg::odt_pair_t   odt_fr;

    // model state
    ddr2_odt_pkg::odt_timing_t tm_hr;
    ddr2_odt_pkg::odt_timing_t tm_fr;
    bit                        wr_hist [0:HIST_LEN-1];
    bit                        rd_hist [0:HIST_LEN-1];
    int                        cyc;
    bit                        reset_active;
    string                     test_name;

    ddr2_odt_top #(
        .DWIDTH_RATIO (4)
    ) u_dut (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cfg         (cfg),
        .do_write    (do_write),
        .do_read     (do_read),
        .odt         (odt_hr)
    );

    ddr2_odt_top #(
        .DWIDTH_RATIO (2)
    ) u_dut_fr (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cfg         (cfg),
        .do_write    (do_write),
        .do_read     (do_read),
        .odt         (odt_fr)
    );

    initial
    begin
        ctl_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ctl_clk = ~ctl_clk;
    end

    initial
    begin
        #((TEST_CYCLES + 200) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic ddr2_odt_pkg::odt_cfg_t make_cfg(int tcl, int al, int bl, bit regd);
        ddr2_odt_pkg::odt_cfg_t c;
        c.tcl          = ddr2_odt_pkg::tcl_t'(tcl);
        c.add_lat      = ddr2_odt_pkg::add_lat_t'(al);
        c.burst_length = ddr2_odt_pkg::burst_len_t'(bl);
        c.output_regd  = regd;
        return c;
    endfunction

    // settled timing for one rate from the latency rules
    function automatic ddr2_odt_pkg::odt_timing_t calc_timing(ddr2_odt_pkg::odt_cfg_t c,
                                                              int ratio);
        ddr2_odt_pkg::odt_timing_t t;
        int half;
        int tcwl;
        half = ratio / 2;
        tcwl = int'(c.tcl) + int'(c.add_lat) + (c.output_regd ? half : 0) - 1;
        t = '0;
        t.tcwl      = ddr2_odt_pkg::tcl_t'(tcwl);
        t.tcwl_even = (tcwl % 2) == 0;
        t.wr_bypass = tcwl < int'(ddr2_odt_pkg::WR_BYPASS_LIMIT);
        t.rd_bypass = tcwl < int'(ddr2_odt_pkg::RD_BYPASS_LIMIT);
        t.wr_tap    = t.wr_bypass ? '0 : ddr2_odt_pkg::tcl_t'((tcwl - 4) / half);
        t.rd_tap    = t.rd_bypass ? '0 : ddr2_odt_pkg::tcl_t'((tcwl - 3) / half);
        t.beats     = ddr2_odt_pkg::beats_t'(int'(c.burst_length) / ratio);
        return t;
    endfunction

    // offset of cycle now from the latest window start or -1 outside any window
    function automatic int window_offset(bit is_wr, ddr2_odt_pkg::odt_timing_t t, int now);
        int  k;
        int  c;
        int  tap;
        bit  byp;
        int  found;
        tap   = is_wr ? int'(t.wr_tap) : int'(t.rd_tap);
        byp   = is_wr ? t.wr_bypass : t.rd_bypass;
        found = -1;
        for (k = 0; k <= int'(t.beats); k++)
        begin
            c = byp ? now - k : now - k - tap - 1;
            if (found < 0 && c >= 0 && (is_wr ? wr_hist[c] : rd_hist[c]))
            begin
                found = k;
            end
        end
        return found;
    endfunction

    function automatic ddr2_odt_pkg::odt_pair_t edge_shape(int k, int beats, bit edge_short);
        ddr2_odt_pkg::odt_pair_t p;
        p = '{h: 1'b1, l: 1'b1};
        if (k == 0)
        begin
            p.l = edge_short;
        end
        else if (k == beats)
        begin
            p.h = ~edge_short;
        end
        return p;
    endfunction

    function automatic ddr2_odt_pkg::odt_pair_t predict_odt(ddr2_odt_pkg::odt_timing_t t,
                                                            int ratio, int now);
        int kw;
        int kr;
        kw = window_offset(1'b1, t, now);
        kr = window_offset(1'b0, t, now);
        if (ratio == 2)
        begin
            return '{h: (kw >= 0 || kr >= 0), l: (kw >= 0 || kr >= 0)};
        end
        else if (kw >= 0)
        begin
            return edge_shape(kw, int'(t.beats), t.tcwl_even);
        end
        else if (kr >= 0)
        begin
            return edge_shape(kr, int'(t.beats), ~t.tcwl_even);
        end
        return '0;
    endfunction

    task automatic compare_pair(input ddr2_odt_pkg::odt_pair_t exp_val,
                                input ddr2_odt_pkg::odt_pair_t act_val, input string what);
        if (exp_val !== act_val)
        begin
            $display("Fail %s: %s cycle %0d expected h=%b l=%b actual h=%b l=%b", test_name,
                     what, cyc, exp_val.h, exp_val.l, act_val.h, act_val.l);
            $display("Test FAILED");
            $fatal(1, "odt mismatch");
        end
    endtask

    task automatic compare_bit(input logic exp_val, input logic act_val, input string what);
        if (exp_val !== act_val)
        begin
            $display("Fail %s: %s expected %b actual %b", test_name, what, exp_val, act_val);
            $display("Test FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // drive one controller cycle after the rising edge and check it at the falling edge
    task automatic step_cycle(input bit wr, input bit rd);
        @(posedge ctl_clk);
        #DRIVE_DLY;
        ctl_reset_n  = ~reset_active;
        do_write     = wr;
        do_read      = rd;
        wr_hist[cyc] = wr;
        rd_hist[cyc] = rd;
        @(negedge ctl_clk);
        compare_pair(predict_odt(tm_hr, 4, cyc), odt_hr, "u_dut odt");
        compare_pair(predict_odt(tm_fr, 2, cyc), odt_fr, "u_dut_fr odt");
        cyc++;
    endtask

    task automatic apply_cfg(input ddr2_odt_pkg::odt_cfg_t new_cfg);
        @(posedge ctl_clk);
        #DRIVE_DLY;
        cfg = new_cfg;
        tm_hr = calc_timing(new_cfg, 4);
        tm_fr = calc_timing(new_cfg, 2);
        @(negedge ctl_clk);
        compare_pair(predict_odt(tm_hr, 4, cyc), odt_hr, "u_dut odt");
        compare_pair(predict_odt(tm_fr, 2, cyc), odt_fr, "u_dut_fr odt");
        cyc++;
        repeat (CFG_IDLE) step_cycle(1'b0, 1'b0);
        compare_bit(tm_hr.tcwl_even, u_dut.timing.tcwl_even, "u_dut tcwl_even");
        compare_bit(tm_hr.wr_bypass, u_dut.timing.wr_bypass, "u_dut wr_bypass");
        compare_bit(tm_hr.rd_bypass, u_dut.timing.rd_bypass, "u_dut rd_bypass");
        compare_bit(tm_fr.wr_bypass, u_dut_fr.timing.wr_bypass, "u_dut_fr wr_bypass");
        compare_bit(tm_fr.rd_bypass, u_dut_fr.timing.rd_bypass, "u_dut_fr rd_bypass");
    endtask

    // full-rate windows are the longer ones and set the spacing
    task automatic issue_cmd(input bit wr, input bit rd, input int extra_gap);
        step_cycle(wr, rd);
        repeat (int'(tm_fr.beats) + 3 + extra_gap) step_cycle(1'b0, 1'b0);
    endtask

    task automatic drain;
        repeat (DRAIN_CYCLES) step_cycle(1'b0, 1'b0);
    endtask

    task automatic reset_idle;
        test_name    = "reset";
        reset_active = 1'b1;
        repeat (RESET_CYCLES) step_cycle(1'b0, 1'b0);
        reset_active = 1'b0;
        repeat (2 * RESET_CYCLES) step_cycle(1'b0, 1'b0);
    endtask

    task automatic delayed_writes;
        test_name = "write_delay";
        apply_cfg(make_cfg(5, 2, 8, 1'b0));
        repeat (3) issue_cmd(1'b1, 1'b0, 0);
        drain();
    endtask

    task automatic delayed_reads;
        test_name = "read_delay";
        apply_cfg(make_cfg(5, 2, 8, 1'b0));
        repeat (3) issue_cmd(1'b0, 1'b1, 0);
        drain();
    endtask

    task automatic bypass_cmds;
        test_name = "bypass";
        apply_cfg(make_cfg(3, 0, 8, 1'b0));
        issue_cmd(1'b1, 1'b0, 0);
        issue_cmd(1'b0, 1'b1, 0);
        issue_cmd(1'b1, 1'b0, 1);
        issue_cmd(1'b0, 1'b1, 2);
        drain();
    endtask

    task automatic output_regd_bursts;
        test_name = "output_regd_bl8";
        apply_cfg(make_cfg(5, 2, 8, 1'b1));
        issue_cmd(1'b1, 1'b0, 0);
        issue_cmd(1'b0, 1'b1, 0);
        drain();
        test_name = "output_regd_bl4";
        apply_cfg(make_cfg(5, 2, 4, 1'b1));
        issue_cmd(1'b1, 1'b0, 0);
        issue_cmd(1'b0, 1'b1, 0);
        issue_cmd(1'b1, 1'b0, 0);
        drain();
    endtask

    task automatic cfg_sweep;
        int i;
        int n;
        test_name = "cfg_sweep";
        for (i = 0; i < 5; i++)
        begin
            apply_cfg(make_cfg(SWEEP_TCL[i], SWEEP_AL[i], 8, SWEEP_REGD[i]));
            for (n = 0; n < MAX_CMDS; n++)
            begin
                issue_cmd(n % 2 == 0, n % 2 == 1, int'($urandom % 4));
            end
            drain();
        end
    endtask

    initial
    begin
        ctl_reset_n  = 1'b0;
        cfg          = make_cfg(5, 2, 8, 1'b0);
        do_write     = 1'b0;
        do_read      = 1'b0;
        tm_hr        = calc_timing(cfg, 4);
        tm_fr        = calc_timing(cfg, 2);
        cyc          = 0;
        reset_active = 1'b1;
        test_name    = "init";
        void'($urandom(RANDOM_SEED));

        reset_idle();
        delayed_writes();
        delayed_reads();
        bypass_cmds();
        output_regd_bursts();
        cfg_sweep();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ddr2_odt.f ====
logic/ddr2_odt_pkg.sv
logic/odt_latency_cfg.sv
logic/odt_cmd_lane.sv
logic/odt_phase_gen.sv
logic/ddr2_odt_top.sv
dv/ddr2_odt_properties.sv
dv/ddr2_odt_tb.sv
